// ==== verilog/or1k_isa_pkg.sv ====
/* OpenRISC instruction encodings that the trace monitor decodes.
   Covers only the l.nop forms used to steer a simulation. */

package or1k_isa_pkg;

   // Width of one OpenRISC instruction word
   localparam int insn_width = 32;

   // Width of the l.nop immediate in the low half of the word
   localparam int nop_imm_width = 16;

   // l.nop with a zero immediate
   // Upper half carries opcode 0x05 and the nop sub-opcode
   localparam logic [insn_width-1:0] nop_base = 32'h1500_0000;

   // Immediates that request a simulation action
   // Stop the run, r3 holds the exit code
   localparam logic [nop_imm_width-1:0] nop_imm_exit = 16'h0001;

   // Print r3 as a value
   localparam logic [nop_imm_width-1:0] nop_imm_report = 16'h0002;

   // Emit the low byte of r3 as a character
   localparam logic [nop_imm_width-1:0] nop_imm_putc = 16'h0004;

   // Kind of one retired instruction
   // Anything that is not a control nop is nop_none
   typedef enum logic [1:0] {
      nop_none   = 2'd0,
      nop_exit   = 2'd1,
      nop_report = 2'd2,
      nop_putc   = 2'd3
   } nop_kind_e;

endpackage

// ==== verilog/trace_pkg.sv ====
/* Retirement trace format and monitor state shared by the trace monitor.
   Field widths follow the core's execution trace. */

package trace_pkg;

   // pc, insn, writeback data and register value width
   localparam int data_width = 32;

   // Register file index width, 32 GPRs
   localparam int reg_idx_width = 5;

   // Register that carries arguments of the control nops
   // r3 is the first argument register in the ABI
   localparam logic [reg_idx_width-1:0] shadow_reg = 5'd3;

   // Retired instruction counter width
   localparam int count_width = 32;

   // Character strobe payload
   localparam int char_width = 8;

   // Event unit state
   // Once terminated only a reset brings it back
   typedef enum logic {
      st_running    = 1'b0,
      st_terminated = 1'b1
   } mon_state_e;

endpackage

// ==== verilog/r3_shadow.sv ====
/* Shadow copy of the core's r3, rebuilt from the writeback part of the trace.
   The value is visible one cycle after the retiring writeback. */

module r3_shadow (
   input  logic                                 clk,
   input  logic                                 arst_n,
   // Writeback part of the retirement trace
   input  logic                                 trace_enable,
   input  logic                                 trace_wben,
   input  logic [trace_pkg::reg_idx_width-1:0]  trace_wbreg,
   input  logic [trace_pkg::data_width-1:0]     trace_wbdata,
   // Current shadowed value
   output logic [trace_pkg::data_width-1:0]     r3_value
);

   // Write hits the shadowed register
   logic hit;

   // Only retired instructions count
   // A squashed writeback never reaches the register file
   assign hit = trace_enable && trace_wben && (trace_wbreg == trace_pkg::shadow_reg);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         // Core resets its GPRs to zero as well
         r3_value <= '0;
      end else if (hit) begin
         r3_value <= trace_wbdata;
      end
   end

   // Register index must be known whenever a retired writeback is flagged
   // An X index would silently drop a write to r3
   assert property (
      @(posedge clk) disable iff (!arst_n)
      (trace_enable && trace_wben) |-> !$isunknown(trace_wbreg)
   ) else $error("r3_shadow: unknown writeback register on retired writeback");

endmodule

// ==== verilog/nop_decoder.sv ====
/* Decodes each retired instruction into a simulation-control nop kind.
   Also counts retired instructions; results are registered one cycle. */

module nop_decoder (
   input  logic                               clk,
   input  logic                               arst_n,
   // Retirement trace
   input  logic                               trace_enable,
   input  logic [trace_pkg::data_width-1:0]   trace_insn,
   // Decoded control nop, one cycle after retirement
   output logic                               nop_valid,
   output or1k_isa_pkg::nop_kind_e            nop_kind,
   // Instructions retired so far including last cycle's
   output logic [trace_pkg::count_width-1:0]  retired_count
);

   // Upper half matches the l.nop opcode
   logic                                        is_nop;
   // Immediate field of the instruction
   logic [or1k_isa_pkg::nop_imm_width-1:0]      nop_imm;
   // Kind of the instruction in the trace this cycle
   or1k_isa_pkg::nop_kind_e                     kind_next;

   assign is_nop = (trace_insn[trace_pkg::data_width-1:or1k_isa_pkg::nop_imm_width] ==
                    or1k_isa_pkg::nop_base[trace_pkg::data_width-1:
                                           or1k_isa_pkg::nop_imm_width]);
   assign nop_imm = trace_insn[or1k_isa_pkg::nop_imm_width-1:0];

   always_comb begin
      kind_next = or1k_isa_pkg::nop_none;
      if (is_nop) begin
         case (nop_imm)
            or1k_isa_pkg::nop_imm_exit:   kind_next = or1k_isa_pkg::nop_exit;
            or1k_isa_pkg::nop_imm_report: kind_next = or1k_isa_pkg::nop_report;
            or1k_isa_pkg::nop_imm_putc:   kind_next = or1k_isa_pkg::nop_putc;
            // Other immediates are plain nops
            default:                      kind_next = or1k_isa_pkg::nop_none;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         nop_valid     <= 1'b0;
         nop_kind      <= or1k_isa_pkg::nop_none;
         retired_count <= '0;
      end else begin
         // Strobe only for a retired control nop
         nop_valid <= trace_enable && (kind_next != or1k_isa_pkg::nop_none);
         nop_kind  <= trace_enable ? kind_next : or1k_isa_pkg::nop_none;
         if (trace_enable) begin
            retired_count <= retired_count +
                             {{(trace_pkg::count_width-1){1'b0}}, 1'b1};
         end
      end
   end

   // Back-to-back strobes need a retirement in each of the two cycles before
   assert property (
      @(posedge clk) disable iff (!arst_n)
      (nop_valid && $past(nop_valid)) |-> ($past(trace_enable, 1) && $past(trace_enable, 2))
   ) else $error("nop_decoder: nop_valid held without back-to-back retirements");

endmodule

// ==== verilog/sim_event_unit.sv ====
/* Turns decoded control nops and the shadowed r3 into putc, report and exit events.
   Exit is sticky and mutes every later event until reset. */

module sim_event_unit (
   input  logic                               clk,
   input  logic                               arst_n,
   // From the decoder, aligned with r3_value
   input  logic                               nop_valid,
   input  or1k_isa_pkg::nop_kind_e            nop_kind,
   input  logic [trace_pkg::count_width-1:0]  retired_count,
   // From the r3 shadow
   input  logic [trace_pkg::data_width-1:0]   r3_value,
   // Character output
   output logic                               putc_valid,
   output logic [trace_pkg::char_width-1:0]   putc_char,
   // Value report
   output logic                               report_valid,
   output logic [trace_pkg::data_width-1:0]   report_value,
   // Termination
   output logic                               terminated,
   output logic [trace_pkg::data_width-1:0]   exit_code,
   output logic [trace_pkg::count_width-1:0]  exit_count
);

   trace_pkg::mon_state_e state;
   trace_pkg::mon_state_e state_next;

   // Per-kind hits while still running
   logic running;
   logic do_putc;
   logic do_report;
   logic do_exit;

   assign running   = (state == trace_pkg::st_running);
   assign do_putc   = running && nop_valid && (nop_kind == or1k_isa_pkg::nop_putc);
   assign do_report = running && nop_valid && (nop_kind == or1k_isa_pkg::nop_report);
   assign do_exit   = running && nop_valid && (nop_kind == or1k_isa_pkg::nop_exit);

   // Next state
   always_comb begin
      state_next = state;
      case (state)
         trace_pkg::st_running: begin
            if (do_exit) begin
               state_next = trace_pkg::st_terminated;
            end
         end
         // No way out except reset
         trace_pkg::st_terminated: begin
            state_next = trace_pkg::st_terminated;
         end
      endcase
   end

   // Control state and strobes
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state        <= trace_pkg::st_running;
         putc_valid   <= 1'b0;
         report_valid <= 1'b0;
      end else begin
         state        <= state_next;
         putc_valid   <= do_putc;
         report_valid <= do_report;
      end
   end

   // Payloads load with their event
   always_ff @(posedge clk) begin
      if (do_putc) begin
         putc_char <= r3_value[trace_pkg::char_width-1:0];
      end
      if (do_report) begin
         report_value <= r3_value;
      end
      // Count already includes the exit nop itself
      if (do_exit) begin
         exit_code  <= r3_value;
         exit_count <= retired_count;
      end
   end

   // Level follows the state register
   // Rises together with the captured exit values
   assign terminated = (state == trace_pkg::st_terminated);

   // Decoder gives one kind per cycle
   assert property (
      @(posedge clk) disable iff (!arst_n)
      !(putc_valid && report_valid)
   ) else $error("sim_event_unit: putc and report strobes together");

   // Nothing escapes after the exit has landed
   assert property (
      @(posedge clk) disable iff (!arst_n)
      $past(terminated) |-> (!putc_valid && !report_valid)
   ) else $error("sim_event_unit: event strobe after termination");

endmodule

// ==== verilog/trace_monitor_top.sv ====
/* Trace monitor for one core: r3 shadow and nop decoder feed the event unit.
   A control nop shows up as an event two cycles after it retires. */

module trace_monitor_top (
   input  logic                                 clk,
   input  logic                                 arst_n,
   // Retirement trace from the core
   input  logic                                 trace_enable,
   input  logic [trace_pkg::data_width-1:0]     trace_pc,
   input  logic [trace_pkg::data_width-1:0]     trace_insn,
   input  logic                                 trace_wben,
   input  logic [trace_pkg::reg_idx_width-1:0]  trace_wbreg,
   input  logic [trace_pkg::data_width-1:0]     trace_wbdata,
   // Simulation events
   output logic                                 putc_valid,
   output logic [trace_pkg::char_width-1:0]     putc_char,
   output logic                                 report_valid,
   output logic [trace_pkg::data_width-1:0]     report_value,
   output logic                                 terminated,
   output logic [trace_pkg::data_width-1:0]     exit_code,
   output logic [trace_pkg::count_width-1:0]    exit_count
);

   // r3 as seen after all earlier writebacks
   logic [trace_pkg::data_width-1:0]   r3_value;
   // Decoded control nop, same cycle as r3_value
   logic                               nop_valid;
   or1k_isa_pkg::nop_kind_e            nop_kind;
   logic [trace_pkg::count_width-1:0]  retired_count;

   r3_shadow u_r3_shadow (
      .clk          (clk),
      .arst_n       (arst_n),
      .trace_enable (trace_enable),
      .trace_wben   (trace_wben),
      .trace_wbreg  (trace_wbreg),
      .trace_wbdata (trace_wbdata),
      .r3_value     (r3_value)
   );

   nop_decoder u_nop_decoder (
      .clk           (clk),
      .arst_n        (arst_n),
      .trace_enable  (trace_enable),
      .trace_insn    (trace_insn),
      .nop_valid     (nop_valid),
      .nop_kind      (nop_kind),
      .retired_count (retired_count)
   );

   sim_event_unit u_sim_event_unit (
      .clk           (clk),
      .arst_n        (arst_n),
      .nop_valid     (nop_valid),
      .nop_kind      (nop_kind),
      .retired_count (retired_count),
      .r3_value      (r3_value),
      .putc_valid    (putc_valid),
      .putc_char     (putc_char),
      .report_valid  (report_valid),
      .report_value  (report_value),
      .terminated    (terminated),
      .exit_code     (exit_code),
      .exit_count    (exit_count)
   );

   // A retiring instruction always has a known pc and word
   assert property (
      @(posedge clk) disable iff (!arst_n)
      trace_enable |-> !$isunknown({trace_pc, trace_insn})
   ) else $error("trace_monitor_top: unknown pc or insn on retirement");

endmodule

// ==== dv/tb_trace_monitor.sv ====
/* Drives random and directed retirement traces into the trace monitor.
   Predicts every event with a reference model and compares all outputs each cycle. */

module tb_trace_monitor;

   localparam int clk_period       = 100;
   localparam int reset_cycles     = 4;
   localparam int idle_cycles      = 8;
   localparam int wb_cycles        = 24;
   localparam int stream_cycles    = 400;
   localparam int post_exit_cycles = 24;
   // Directed writes, nops, flushes and the second reset
   localparam int total_cycles = 2 * reset_cycles + idle_cycles + wb_cycles + stream_cycles +
                                 post_exit_cycles + 40;
   localparam int watchdog_margin = 200;

   // Expected outputs two cycles after one driven cycle
   typedef struct packed {
      logic        putc_v;
      logic [7:0]  putc_c;
      logic        rep_v;
      logic [31:0] rep_val;
      logic        term;
      logic [31:0] code;
      logic [31:0] count;
   } exp_t;

   logic        clk;
   logic        arst_n;
   logic        trace_enable;
   logic [31:0] trace_pc;
   logic [31:0] trace_insn;
   logic        trace_wben;
   logic [4:0]  trace_wbreg;
   logic [31:0] trace_wbdata;
   logic        putc_valid;
   logic [7:0]  putc_char;
   logic        report_valid;
   logic [31:0] report_value;
   logic        terminated;
   logic [31:0] exit_code;
   logic [31:0] exit_count;

   // Reference model state
   logic [31:0] m_r3;
   logic [31:0] m_count;
   logic        m_term;
   logic [31:0] m_exit_code;
   logic [31:0] m_exit_count;
   exp_t        exp_q[$];
   exp_t        cur;

   logic [31:0] rng_state;
   logic [31:0] pc_next;
   int          err_count;
   int          test_err_base;
   int          test_num;
   int          n_checks;

   trace_monitor_top uut (
      .clk          (clk),
      .arst_n       (arst_n),
      .trace_enable (trace_enable),
      .trace_pc     (trace_pc),
      .trace_insn   (trace_insn),
      .trace_wben   (trace_wben),
      .trace_wbreg  (trace_wbreg),
      .trace_wbdata (trace_wbdata),
      .putc_valid   (putc_valid),
      .putc_char    (putc_char),
      .report_valid (report_valid),
      .report_value (report_value),
      .terminated   (terminated),
      .exit_code    (exit_code),
      .exit_count   (exit_count)
   );

   always #(clk_period / 2) clk = ~clk;

   // Numerical Recipes LCG constants
   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1664525 + 32'd1013904223;
      return rng_state;
   endfunction

   // Random word that never decodes as l.nop
   function automatic logic [31:0] plain_insn();
      logic [31:0] w;
      w = next_rand();
      if (w[31:16] == or1k_isa_pkg::nop_base[31:16]) begin
         w[31] = ~w[31];
      end
      return w;
   endfunction

   // Steps the model by one driven cycle and queues what shows two cycles later
   function automatic void ref_step(input logic en, input logic [31:0] insn, input logic wben,
                                    input logic [4:0] wbreg, input logic [31:0] wbdata);
      exp_t e;
      e = '0;
      if (en) begin
         m_count = m_count + 32'd1;
         // Control nop sees r3 from earlier writebacks only
         if (insn[31:16] == or1k_isa_pkg::nop_base[31:16] && !m_term) begin
            case (insn[15:0])
               16'h0001: begin
                  m_term       = 1'b1;
                  m_exit_code  = m_r3;
                  m_exit_count = m_count;
               end
               16'h0002: begin
                  e.rep_v   = 1'b1;
                  e.rep_val = m_r3;
               end
               16'h0004: begin
                  e.putc_v = 1'b1;
                  e.putc_c = m_r3[7:0];
               end
               default: begin
               end
            endcase
         end
         if (wben && wbreg == trace_pkg::shadow_reg) begin
            m_r3 = wbdata;
         end
      end
      e.term  = m_term;
      e.code  = m_exit_code;
      e.count = m_exit_count;
      exp_q.push_back(e);
   endfunction

   task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] act);
      $display("error %s expected %h actual %h at %0t", name, exp, act, $time);
      err_count++;
   endtask

   // One queued entry per cycle once the two-cycle pipe is full
   always @(negedge clk) begin
      if (exp_q.size() == 3) begin
         cur = exp_q.pop_front();
         n_checks++;
         if (putc_valid !== cur.putc_v) begin
            mismatch("putc_valid", {31'b0, cur.putc_v}, {31'b0, putc_valid});
         end
         if (cur.putc_v && putc_char !== cur.putc_c) begin
            mismatch("putc_char", {24'b0, cur.putc_c}, {24'b0, putc_char});
         end
         if (report_valid !== cur.rep_v) begin
            mismatch("report_valid", {31'b0, cur.rep_v}, {31'b0, report_valid});
         end
         if (cur.rep_v && report_value !== cur.rep_val) begin
            mismatch("report_value", cur.rep_val, report_value);
         end
         if (terminated !== cur.term) begin
            mismatch("terminated", {31'b0, cur.term}, {31'b0, terminated});
         end
         if (cur.term && exit_code !== cur.code) mismatch("exit_code", cur.code, exit_code);
         if (cur.term && exit_count !== cur.count) mismatch("exit_count", cur.count, exit_count);
      end
   end

   task automatic drive(input logic en, input logic [31:0] insn, input logic wben,
                        input logic [4:0] wbreg, input logic [31:0] wbdata);
      @(posedge clk);
      trace_enable <= en;
      trace_pc     <= pc_next;
      trace_insn   <= insn;
      trace_wben   <= wben;
      trace_wbreg  <= wbreg;
      trace_wbdata <= wbdata;
      if (en) begin
         pc_next = pc_next + 32'd4;
      end
      ref_step(en, insn, wben, wbreg, wbdata);
   endtask

   task automatic drive_idle();
      drive(1'b0, 32'h0, 1'b0, 5'd0, 32'h0);
   endtask

   task automatic drive_wb(input logic [4:0] wbreg, input logic [31:0] wbdata);
      drive(1'b1, plain_insn(), 1'b1, wbreg, wbdata);
   endtask

   // Nops never write a register
   task automatic drive_nop(input logic [15:0] imm);
      drive(1'b1, or1k_isa_pkg::nop_base | {16'h0, imm}, 1'b0, 5'd0, 32'h0);
   endtask

   // Mix of idle, ordinary, putc, report and odd-immediate nops
   task automatic random_stream(input int n);
      logic [31:0] r;
      logic [15:0] imm;
      for (int i = 0; i < n; i++) begin
         r = next_rand();
         imm = r[31:16];
         if (imm == 16'h0001 || imm == 16'h0002 || imm == 16'h0004) begin
            imm = 16'h0000;
         end
         case (r[2:0])
            // Garbage writeback to r3 that must be ignored
            3'd0: drive(1'b0, plain_insn(), 1'b1, trace_pkg::shadow_reg, next_rand());
            3'd1: drive_nop(16'h0004);
            3'd2: drive_nop(16'h0002);
            3'd3: drive_nop(imm);
            default: drive(1'b1, plain_insn(), r[7:6] != 2'd0,
                           r[8] ? trace_pkg::shadow_reg : r[13:9], next_rand());
         endcase
      end
   endtask

   // Idle cycles until the last driven cycle has passed the comparator
   task automatic flush();
      repeat (3) drive_idle();
   endtask

   task automatic do_reset();
      @(posedge clk);
      arst_n       <= 1'b0;
      trace_enable <= 1'b0;
      trace_wben   <= 1'b0;
      exp_q.delete();
      m_r3    = '0;
      m_count = '0;
      m_term  = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      arst_n <= 1'b1;
   endtask

   task automatic finish_test(input string name);
      flush();
      test_num++;
      $display("test %0d %s: %s, %0d errors", test_num, name,
               (err_count == test_err_base) ? "ok" : "bad", err_count - test_err_base);
      test_err_base = err_count;
   endtask

   // Watchdog sized from the test lengths
   initial begin
      #((total_cycles + watchdog_margin) * clk_period);
      $display("timeout: the tests did not finish in the expected number of cycles");
      $display("sim failed");
      $finish;
   end

   initial begin
      clk           = 1'b0;
      arst_n        = 1'b0;
      trace_enable  = 1'b0;
      trace_pc      = '0;
      trace_insn    = '0;
      trace_wben    = 1'b0;
      trace_wbreg   = '0;
      trace_wbdata  = '0;
      rng_state     = 32'hac8a;
      pc_next       = 32'h0000_0100;
      m_r3          = '0;
      m_count       = '0;
      m_term        = 1'b0;
      m_exit_code   = '0;
      m_exit_count  = '0;
      err_count     = 0;
      test_err_base = 0;
      test_num      = 0;
      n_checks      = 0;
      repeat (reset_cycles) @(posedge clk);
      arst_n <= 1'b1;

      repeat (idle_cycles) drive_idle();
      finish_test("idle after reset");

      // Many registers with r3 among them, then putc
      drive_wb(trace_pkg::shadow_reg, next_rand());
      for (int i = 0; i < wb_cycles; i++) begin
         drive_wb(rng_state[4:0], next_rand());
      end
      drive_nop(16'h0004);
      finish_test("putc after random writebacks");

      // Report right behind the r3 write
      drive_wb(trace_pkg::shadow_reg, 32'hdead_beef);
      drive_nop(16'h0002);
      drive_wb(trace_pkg::shadow_reg, 32'h1234_5678);
      drive_nop(16'h0002);
      drive_nop(16'h0004);
      finish_test("report alignment");

      random_stream(stream_cycles);
      finish_test("random back-to-back stream");

      drive_wb(trace_pkg::shadow_reg, next_rand());
      drive_wb(5'd7, next_rand());
      drive_nop(16'h0001);
      random_stream(post_exit_cycles);
      // Second exit must not overwrite the captured values
      drive_wb(trace_pkg::shadow_reg, 32'h0bad_0bad);
      drive_nop(16'h0001);
      flush();
      do_reset();
      repeat (4) drive_idle();
      finish_test("exit and sticky termination");

      if (n_checks == 0) begin
         $display("no output comparisons took place");
         err_count++;
      end
      $display("%0d tests, %0d cycles checked, %0d errors", test_num, n_checks, err_count);
      if (err_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// ==== vlog.f ====
verilog/or1k_isa_pkg.sv
verilog/trace_pkg.sv
verilog/r3_shadow.sv
verilog/nop_decoder.sv
verilog/sim_event_unit.sv
verilog/trace_monitor_top.sv
dv/tb_trace_monitor.sv

// ==== Makefile ====
# Verilator build and run for the trace monitor

TOOL      = verilator
FLAGS     = --binary --timing --assert
LINTFLAGS = --lint-only --timing -Wall
TOP       = tb_trace_monitor
FILELIST  = vlog.f
OBJDIR    = obj_dir
LOG       = sim.log
PASS      = sim passed

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o $(TOP)

run: build
	./$(OBJDIR)/$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS)" $(LOG); then \
		echo "result: pass"; \
	else \
		echo "result: fail"; \
		exit 1; \
	fi

lint:
	$(TOOL) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
